// File: all.f
pcie_hdr_pkg.sv
he_cfg_pkg.sv
tlp_rx_decode.sv
tlp_skid.sv
he_lb_engine.sv
he_mem_engine.sv
he_csr.sv
port_afu_instances.sv
tb_port_afu.sv

// File: tb_port_afu.sv
`timescale 1ns/1ps
// Directed testbench for a three port group. Drives the request streams and
// the APB bus, predicts completions and register values from a small model,
// and checks them one test at a time. Port 1 carries the memory exerciser.

module tb_port_afu
   import pcie_hdr_pkg::*;
   import he_cfg_pkg::*;
();

   localparam int NPORTS      = 3;
   localparam int MEM_IDX     = 1;
   localparam int BANKS       = 2;
   localparam int WORDS       = 16;
   localparam int LB_READS    = 8;
   localparam int RDY_TIMEOUT = 50;
   localparam int CPL_TIMEOUT = 300;
   localparam int APB_TIMEOUT = 10;
   localparam int POLL_LIMIT  = 20;

   // every port answers to its own PF/VF identity
   localparam pf_vf_info_t MAP0 = '{pf_num: 3'd0, vf_num: 11'd0, vf_active: 1'b0};
   localparam pf_vf_info_t MAP1 = '{pf_num: 3'd1, vf_num: 11'd0, vf_active: 1'b0};
   localparam pf_vf_info_t MAP2 = '{pf_num: 3'd0, vf_num: 11'd5, vf_active: 1'b1};
   localparam pf_vf_info_t [NPORTS-1:0] PF_MAP = {MAP2, MAP1, MAP0};

   logic                    clk = 1'b0;
   logic                    rst_n;
   req_beat_t [NPORTS-1:0]  rx_beat;
   logic [NPORTS-1:0]       rx_valid;
   logic [NPORTS-1:0]       rx_ready;
   cpl_beat_t [NPORTS-1:0]  tx_beat;
   logic [NPORTS-1:0]       tx_valid;
   logic [NPORTS-1:0]       tx_ready;
   logic [CSR_ADDR_W-1:0]   paddr;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [31:0]             pwdata;
   logic [31:0]             prdata;
   logic                    pready;
   logic                    pslverr;

   integer      seed;
   int          cyc;
   int          errors;
   int          checks;
   string       cur_test;
   logic [31:0] seed_m [NPORTS];
   // reference memory, one entry per bank and word pair
   logic [31:0] mem_m [BANKS*WORDS];
   cpl_beat_t   exp_q [$];
   cpl_beat_t   got_q [$];
   int          got_port_q [$];
   int          got_cyc_q [$];
   int          acc_q [$];
   logic        bp_mode;
   logic [255:0] bp_pat;
   int          bp_idx;

   port_afu_instances #(
      .PG_NUM_PORTS(NPORTS),
      .PORT_PF_VF_INFO(PF_MAP),
      .HE_MEM_IDX(MEM_IDX),
      .NUM_MEM_BANKS(BANKS),
      .BANK_WORDS(WORDS)
   ) dut0 (
      .clk, .rst_n,
      .rx_beat, .rx_valid, .rx_ready,
      .tx_beat, .tx_valid, .tx_ready,
      .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
   );

   initial begin
      forever #50 clk = ~clk;
   end

   // counts rising edges, so a handshake seen at a falling edge lands on cyc + 1
   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // ==========================================================================
   // completion collector, also owns tx_ready
   // ==========================================================================

   always @(negedge clk) begin
      for (int p = 0; p < NPORTS; p++) begin
         // port 0 follows a random ready pattern during the back-pressure test
         if (p == 0 && bp_mode) begin
            tx_ready[p] = bp_pat[bp_idx];
            bp_idx = (bp_idx + 1) % 256;
         end else begin
            tx_ready[p] = 1'b1;
         end
         if (tx_valid[p] && tx_ready[p]) begin
            got_q.push_back(tx_beat[p]);
            got_port_q.push_back(p);
            got_cyc_q.push_back(cyc + 1);
         end
      end
   end

   task automatic check_val(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      end
   endtask

   task automatic report_test(input int e0);
      $display("%s: finished with %0d errors", cur_test, errors - e0);
   endtask

   // bank from the dword address, word from the bits above the bank select
   function automatic int mem_key(input logic [31:0] addr);
      int dw;
      int bank;
      int word;
      dw   = int'(addr >> 2);
      bank = dw % BANKS;
      word = (dw / BANKS) % WORDS;
      return bank * WORDS + word;
   endfunction

   // all tasks below start and end just after a falling edge
   task automatic csr_cycle(input bit wr, input int port, input logic [4:0] offset,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
      int t;
      paddr   = {port[2:0], offset};
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      t = 0;
      while (!pready && t < APB_TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!pready) begin
         errors++;
         $display("%s: APB access never completed", cur_test);
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input int port, input logic [4:0] offset, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused;
      csr_cycle(1'b1, port, offset, data, unused, err);
   endtask

   task automatic apb_read(input int port, input logic [4:0] offset, output logic [31:0] data,
                           output logic err);
      csr_cycle(1'b0, port, offset, 32'd0, data, err);
   endtask

   task automatic expect_reg(input string what, input int port, input logic [4:0] offset,
                             input logic [31:0] expected);
      logic [31:0] rd;
      logic        err;
      apb_read(port, offset, rd, err);
      check_val($sformatf("%s port %0d pslverr", what, port), 0, err);
      check_val($sformatf("%s port %0d", what, port), expected, rd);
   endtask

   // holds the beat on rx until the port takes it
   task automatic send_req(input int port, input tlp_fmt_e fmt, input pf_vf_info_t pf_vf,
                           input logic [7:0] tag, input logic [31:0] addr,
                           input logic [31:0] data);
      int t;
      rx_beat[port]  = '{fmt: fmt, pf_vf: pf_vf, tag: tag, addr: addr, data: data};
      rx_valid[port] = 1'b1;
      t = 0;
      while (!rx_ready[port] && t < RDY_TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!rx_ready[port]) begin
         errors++;
         $display("%s: port %0d did not accept a request in time", cur_test, port);
      end else if (fmt == MRD) begin
         acc_q.push_back(cyc + 1);
      end
      @(negedge clk);
      rx_valid[port] = 1'b0;
   endtask

   // waits for every expected completion, then compares them in order
   task automatic compare_cpls(input int port, input bit check_lat);
      int        n;
      int        t;
      int        i;
      cpl_beat_t exp_b;
      n = exp_q.size();
      t = 0;
      while (got_q.size() < n && t < CPL_TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (got_q.size() < n) begin
         errors++;
         $display("%s: only %0d of %0d completions arrived", cur_test, got_q.size(), n);
      end else begin
         check_val("completion count", n, got_q.size());
      end
      i = 0;
      while (exp_q.size() > 0 && got_q.size() > 0) begin
         exp_b = exp_q.pop_front();
         check_val($sformatf("completion %0d", i), exp_b, got_q.pop_front());
         check_val($sformatf("completion %0d port", i), port, got_port_q.pop_front());
         if (check_lat && acc_q.size() > 0)
            check_val($sformatf("completion %0d latency", i), 4,
                      got_cyc_q.pop_front() - acc_q.pop_front());
         i++;
      end
      exp_q.delete();
      got_q.delete();
      got_port_q.delete();
      got_cyc_q.delete();
      acc_q.delete();
   endtask

   // ==========================================================================
   // tests
   // ==========================================================================

   task automatic reset_and_csr();
      int          e0;
      logic        err;
      logic [31:0] rd;
      logic [31:0] s;
      cur_test = "reset_and_csr";
      e0 = errors;
      rst_n = 1'b0;
      repeat (8) @(negedge clk);
      check_val("rx_ready in reset", 0, rx_ready);
      check_val("tx_valid in reset", 0, tx_valid);
      check_val("pslverr in reset", 0, pslverr);
      rst_n = 1'b1;
      @(negedge clk);
      for (int p = 0; p < NPORTS; p++) begin
         expect_reg("enable after reset", p, CSR_ENABLE, 32'd0);
         expect_reg("reqs after reset", p, CSR_REQS, 32'd0);
         expect_reg("drops after reset", p, CSR_DROPS, 32'd0);
         expect_reg("sum after reset", p, CSR_SUM, 32'd0);
      end
      for (int p = 0; p < NPORTS; p++) begin
         s = $random(seed);
         apb_write(p, CSR_SEED, s, err);
         check_val($sformatf("seed write port %0d pslverr", p), 0, err);
         seed_m[p] = s;
         expect_reg("seed readback", p, CSR_SEED, s);
      end
      apb_read(0, 5'h14, rd, err);
      check_val("unmapped offset pslverr", 1, err);
      apb_read(3, CSR_ENABLE, rd, err);
      check_val("port 3 pslverr", 1, err);
      apb_write(0, CSR_REQS, 32'h0000_1234, err);
      check_val("counter write pslverr", 1, err);
      report_test(e0);
   endtask

   task automatic loopback_reads();
      int          e0;
      logic        err;
      logic [31:0] addr;
      cpl_beat_t   b;
      cur_test = "loopback_reads";
      e0 = errors;
      apb_write(0, CSR_ENABLE, 32'd1, err);
      check_val("enable pslverr", 0, err);
      for (int i = 0; i < LB_READS; i++) begin
         addr = $random(seed) & 32'hFFFF_FFFC;
         b = '{fmt: CPLD, pf_vf: MAP0, tag: i[7:0] + 8'h40, data: addr ^ seed_m[0]};
         exp_q.push_back(b);
         send_req(0, MRD, MAP0, b.tag, addr, 32'd0);
      end
      compare_cpls(0, 1'b1);
      report_test(e0);
   endtask

   task automatic mem_exerciser();
      int          e0;
      int          nreq;
      logic        err;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] sum;
      cpl_beat_t   b;
      cur_test = "mem_exerciser";
      e0 = errors;
      nreq = 0;
      sum = 32'd0;
      apb_write(MEM_IDX, CSR_ENABLE, 32'd1, err);
      check_val("enable pslverr", 0, err);
      // random addresses alias onto the 32 words, so later writes overwrite
      for (int i = 0; i < 24; i++) begin
         addr = $random(seed) & 32'hFFFF_FFFC;
         data = $random(seed);
         mem_m[mem_key(addr)] = data;
         sum = sum ^ data;
         send_req(MEM_IDX, MWR, MAP1, i[7:0], addr, data);
         nreq++;
      end
      // visit every bank and word once, with random upper address bits
      for (int bank = 0; bank < BANKS; bank++) begin
         for (int word = 0; word < WORDS; word++) begin
            addr = 32'(word * BANKS + bank + BANKS * WORDS * ($random(seed) & 255)) << 2;
            b = '{fmt: CPLD, pf_vf: MAP1, tag: 8'(nreq), data: mem_m[mem_key(addr)]};
            exp_q.push_back(b);
            send_req(MEM_IDX, MRD, MAP1, b.tag, addr, 32'd0);
            nreq++;
         end
      end
      compare_cpls(MEM_IDX, 1'b1);
      expect_reg("request count", MEM_IDX, CSR_REQS, nreq);
      expect_reg("checksum", MEM_IDX, CSR_SUM, sum);
      report_test(e0);
   endtask

   task automatic routing_drops();
      int          e0;
      pf_vf_info_t wrong_map;
      cpl_beat_t   b;
      cur_test = "routing_drops";
      e0 = errors;
      wrong_map = MAP0;
      wrong_map.vf_active = 1'b1;
      send_req(0, MRD, MAP1, 8'h80, 32'h0000_0100, 32'd0);
      send_req(0, MRD, wrong_map, 8'h81, 32'h0000_0104, 32'd0);
      // port 2 has not been enabled yet
      send_req(2, MRD, MAP2, 8'h82, 32'h0000_0200, 32'd0);
      send_req(2, MWR, MAP2, 8'h83, 32'h0000_0204, 32'hDEAD_BEEF);
      repeat (12) @(negedge clk);
      check_val("completions from dropped beats", 0, got_q.size());
      got_q.delete();
      got_port_q.delete();
      got_cyc_q.delete();
      acc_q.delete();
      expect_reg("drops", 0, CSR_DROPS, 32'd2);
      expect_reg("drops", 2, CSR_DROPS, 32'd2);
      expect_reg("reqs", 0, CSR_REQS, LB_READS);
      expect_reg("reqs", 2, CSR_REQS, 32'd0);
      // a properly routed read still passes after the drops
      b = '{fmt: CPLD, pf_vf: MAP0, tag: 8'h84, data: 32'h0000_0300 ^ seed_m[0]};
      exp_q.push_back(b);
      send_req(0, MRD, MAP0, 8'h84, 32'h0000_0300, 32'd0);
      compare_cpls(0, 1'b1);
      report_test(e0);
   endtask

   task automatic loopback_checksum();
      int          e0;
      int          t;
      logic        err;
      logic [31:0] sum;
      logic [31:0] d;
      logic [31:0] rd;
      cur_test = "loopback_checksum";
      e0 = errors;
      apb_write(2, CSR_ENABLE, 32'd1, err);
      check_val("enable pslverr", 0, err);
      sum = 32'd0;
      for (int i = 0; i < 10; i++) begin
         d = $random(seed);
         sum = sum ^ d;
         send_req(2, MWR, MAP2, i[7:0], 32'h0000_1000 + 32'(i) * 4, d);
      end
      // writes are posted, the request counter shows when all are consumed
      t = 0;
      rd = 32'd0;
      while (rd != 32'd10 && t < POLL_LIMIT) begin
         apb_read(2, CSR_REQS, rd, err);
         t++;
      end
      if (rd != 32'd10) begin
         errors++;
         $display("%s: port 2 did not consume all writes in time", cur_test);
      end
      expect_reg("checksum", 2, CSR_SUM, sum);
      check_val("completions for writes", 0, got_q.size());
      report_test(e0);
   endtask

   task automatic tx_backpressure();
      int          e0;
      logic [31:0] addr;
      cpl_beat_t   b;
      cur_test = "tx_backpressure";
      e0 = errors;
      for (int i = 0; i < 8; i++)
         bp_pat[i*32 +: 32] = $random(seed);
      bp_idx  = 0;
      bp_mode = 1'b1;
      for (int i = 0; i < 20; i++) begin
         addr = $random(seed) & 32'hFFFF_FFFC;
         b = '{fmt: CPLD, pf_vf: MAP0, tag: i[7:0] + 8'hA0, data: addr ^ seed_m[0]};
         exp_q.push_back(b);
         send_req(0, MRD, MAP0, b.tag, addr, 32'd0);
      end
      compare_cpls(0, 1'b0);
      bp_mode = 1'b0;
      expect_reg("reqs", 0, CSR_REQS, LB_READS + 21);
      report_test(e0);
   endtask

   initial begin
      seed     = 32'h52c1_60b3;
      errors   = 0;
      checks   = 0;
      cur_test = "setup";
      bp_mode  = 1'b0;
      bp_pat   = '0;
      bp_idx   = 0;
      rst_n    = 1'b0;
      rx_beat  = '0;
      rx_valid = '0;
      tx_ready = '1;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = 32'd0;
      for (int p = 0; p < NPORTS; p++)
         seed_m[p] = 32'd0;
      for (int k = 0; k < BANKS * WORDS; k++)
         mem_m[k] = 32'd0;

      reset_and_csr();
      loopback_reads();
      mem_exerciser();
      routing_drops();
      loopback_checksum();
      tx_backpressure();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: port_afu_instances.sv
`timescale 1ns/1ps
// Top level of one port group. Builds a decode, skid, engine, skid pipeline
// per port and one shared APB register block. The port at HE_MEM_IDX gets
// the memory exerciser, every other port the loopback exerciser.

module port_afu_instances
   import pcie_hdr_pkg::*;
   import he_cfg_pkg::*;
#(
   parameter int                              PG_NUM_PORTS    = 1,
   // PF/VF identity of each port, requests must match it exactly
   parameter pf_vf_info_t [PG_NUM_PORTS-1:0] PORT_PF_VF_INFO = '0,
   parameter int                              HE_MEM_IDX      = 0,
   parameter int                              NUM_MEM_BANKS   = 2,
   parameter int                              BANK_WORDS      = 16
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // host request streams, one per port
   input  req_beat_t [PG_NUM_PORTS-1:0]  rx_beat,
   input  logic [PG_NUM_PORTS-1:0]       rx_valid,
   output logic [PG_NUM_PORTS-1:0]       rx_ready,
   // completion streams back to the host
   output cpl_beat_t [PG_NUM_PORTS-1:0]  tx_beat,
   output logic [PG_NUM_PORTS-1:0]       tx_valid,
   input  logic [PG_NUM_PORTS-1:0]       tx_ready,
   // configuration bus
   input  logic [CSR_ADDR_W-1:0]         paddr,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [31:0]                   pwdata,
   output logic [31:0]                   prdata,
   output logic                          pready,
   output logic                          pslverr
);

   port_cfg_t [PG_NUM_PORTS-1:0]  cfg;
   logic [PG_NUM_PORTS-1:0][15:0] reqs;
   logic [PG_NUM_PORTS-1:0][31:0] checksum;
   logic [PG_NUM_PORTS-1:0]       drop;

   // the CSR window only has three port select bits
   if (PG_NUM_PORTS > MAX_PORTS) begin : g_bad_ports
      $error("PG_NUM_PORTS exceeds MAX_PORTS");
   end

   he_csr #(
      .PG_NUM_PORTS(PG_NUM_PORTS)
   ) u_csr (
      .clk, .rst_n,
      .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
      .cfg, .reqs, .checksum, .drop
   );

   // ==========================================================================
   // per-port pipelines, four register stages from rx to tx
   // ==========================================================================

   for (genvar j = 0; j < PG_NUM_PORTS; j++) begin : g_port
      req_beat_t dec_beat;
      logic      dec_valid;
      logic      dec_ready;
      req_beat_t eng_beat;
      logic      eng_valid;
      logic      eng_ready;
      cpl_beat_t eng_cpl_beat;
      logic      eng_cpl_valid;
      logic      eng_cpl_ready;

      tlp_rx_decode #(
         .PORT_PF_VF(PORT_PF_VF_INFO[j])
      ) u_decode (
         .clk, .rst_n, .cfg(cfg[j]),
         .rx_beat(rx_beat[j]), .rx_valid(rx_valid[j]), .rx_ready(rx_ready[j]),
         .out_beat(dec_beat), .out_valid(dec_valid), .out_ready(dec_ready),
         .drop(drop[j])
      );

      tlp_skid #(.ITEM_T(req_beat_t)) u_req_skid (
         .clk, .rst_n,
         .in_item(dec_beat), .in_valid(dec_valid), .in_ready(dec_ready),
         .out_item(eng_beat), .out_valid(eng_valid), .out_ready(eng_ready)
      );

      if (j == HE_MEM_IDX) begin : g_mem
         he_mem_engine #(
            .NUM_MEM_BANKS(NUM_MEM_BANKS),
            .BANK_WORDS(BANK_WORDS)
         ) u_engine (
            .clk, .rst_n, .cfg(cfg[j]),
            .req_beat(eng_beat), .req_valid(eng_valid), .req_ready(eng_ready),
            .cpl_beat(eng_cpl_beat), .cpl_valid(eng_cpl_valid), .cpl_ready(eng_cpl_ready),
            .reqs(reqs[j]), .checksum(checksum[j])
         );
      end else begin : g_lb
         he_lb_engine u_engine (
            .clk, .rst_n, .cfg(cfg[j]),
            .req_beat(eng_beat), .req_valid(eng_valid), .req_ready(eng_ready),
            .cpl_beat(eng_cpl_beat), .cpl_valid(eng_cpl_valid), .cpl_ready(eng_cpl_ready),
            .reqs(reqs[j]), .checksum(checksum[j])
         );
      end

      // egress skid absorbs host back-pressure before it reaches the engine
      tlp_skid #(.ITEM_T(cpl_beat_t)) u_cpl_skid (
         .clk, .rst_n,
         .in_item(eng_cpl_beat), .in_valid(eng_cpl_valid), .in_ready(eng_cpl_ready),
         .out_item(tx_beat[j]), .out_valid(tx_valid[j]), .out_ready(tx_ready[j])
      );
   end

endmodule

// File: he_csr.sv
`timescale 1ns/1ps
// APB register block of the port group. Each port owns a 32 byte window
// with its enable and seed, plus read-only request, drop and checksum
// counters. Responses are prepared in the setup phase, so pready stays 1.

module he_csr
   import he_cfg_pkg::*;
#(
   parameter int PG_NUM_PORTS = 1
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [CSR_ADDR_W-1:0]          paddr,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [31:0]                    pwdata,
   output logic [31:0]                    prdata,
   output logic                           pready,
   output logic                           pslverr,
   output port_cfg_t [PG_NUM_PORTS-1:0]   cfg,
   input  logic [PG_NUM_PORTS-1:0][15:0]  reqs,
   input  logic [PG_NUM_PORTS-1:0][31:0]  checksum,
   input  logic [PG_NUM_PORTS-1:0]        drop
);

   logic [2:0]                    port_idx;
   logic [4:0]                    offset;
   logic                          port_ok;
   logic                          setup;
   logic                          access;
   logic                          err;
   logic [31:0]                   rd_val;
   logic [PG_NUM_PORTS-1:0][15:0] drops;
   port_cnt_t                     sel_cnt;
   port_cfg_t                     sel_cfg;

   assign port_idx = paddr[7:5];
   assign offset   = paddr[4:0];
   assign port_ok  = (int'(port_idx) < PG_NUM_PORTS);
   assign setup    = psel && !penable;
   assign access   = psel && penable;
   assign pready   = 1'b1;

   // ==========================================================================
   // address decode and read mux
   // ==========================================================================

   always_comb begin
      sel_cnt = '0;
      sel_cfg = '0;
      rd_val  = 32'd0;
      err     = 1'b0;
      if (port_ok) begin
         sel_cnt.reqs     = reqs[port_idx];
         sel_cnt.drops    = drops[port_idx];
         sel_cnt.checksum = checksum[port_idx];
         sel_cfg          = cfg[port_idx];
      end
      // counters are read only, a write to one is an error
      case (offset)
         CSR_ENABLE: rd_val = {31'd0, sel_cfg.enable};
         CSR_SEED:   rd_val = sel_cfg.seed;
         CSR_REQS: begin
            rd_val = {16'd0, sel_cnt.reqs};
            err    = pwrite;
         end
         CSR_DROPS: begin
            rd_val = {16'd0, sel_cnt.drops};
            err    = pwrite;
         end
         CSR_SUM: begin
            rd_val = sel_cnt.checksum;
            err    = pwrite;
         end
         default: err = 1'b1;
      endcase
      if (!port_ok)
         err = 1'b1;
   end

   // ==========================================================================
   // response, configuration and drop counters
   // ==========================================================================

   always_ff @(posedge clk) begin
      if (!rst_n)
         pslverr <= 1'b0;
      else
         pslverr <= setup && err;
   end

   always_ff @(posedge clk) begin
      if (setup)
         prdata <= rd_val;
   end

   // writes commit in the access phase unless setup flagged an error
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg <= '0;
      end else if (access && pwrite && !pslverr) begin
         if (offset == CSR_ENABLE)
            cfg[port_idx].enable <= pwdata[0];
         else if (offset == CSR_SEED)
            cfg[port_idx].seed <= pwdata;
      end
   end

   // drop counters saturate rather than wrap
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         drops <= '0;
      end else begin
         for (int p = 0; p < PG_NUM_PORTS; p++) begin
            if (drop[p] && drops[p] != 16'hFFFF)
               drops[p] <= drops[p] + 16'd1;
         end
      end
   end

endmodule

// File: he_mem_engine.sv
`timescale 1ns/1ps
// Memory exerciser stage. Writes land in banked local memory and reads
// return the stored word one cycle later. Counters match the loopback
// engine, so the host sees the same statistics on every port.

module he_mem_engine
   import pcie_hdr_pkg::*;
   import he_cfg_pkg::*;
#(
   parameter int NUM_MEM_BANKS = 2,
   parameter int BANK_WORDS    = 16
) (
   input  logic        clk,
   input  logic        rst_n,
   input  port_cfg_t   cfg,
   input  req_beat_t   req_beat,
   input  logic        req_valid,
   output logic        req_ready,
   output cpl_beat_t   cpl_beat,
   output logic        cpl_valid,
   input  logic        cpl_ready,
   output logic [15:0] reqs,
   output logic [31:0] checksum
);

   localparam int BANK_IW = (NUM_MEM_BANKS > 1) ? $clog2(NUM_MEM_BANKS) : 1;
   localparam int WORD_IW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

   logic [31:0]                              mem [NUM_MEM_BANKS][BANK_WORDS];
   logic [NUM_MEM_BANKS-1:0][BANK_WORDS-1:0] written;
   logic [29:0]                              dw_addr;
   logic [BANK_IW-1:0]                       bank;
   logic [WORD_IW-1:0]                       word;
   logic [31:0]                              rd_data;
   logic                                     accept;
   logic                                     is_rd;
   logic                                     is_wr;

   // consecutive dwords rotate through the banks, then step the word
   assign dw_addr = req_beat.addr[31:2];
   assign bank    = BANK_IW'(dw_addr % NUM_MEM_BANKS);
   assign word    = WORD_IW'((dw_addr / NUM_MEM_BANKS) % BANK_WORDS);
   // words never written read as zero
   assign rd_data = written[bank][word] ? mem[bank][word] : 32'd0;

   assign req_ready = !cpl_valid || cpl_ready;
   assign accept    = req_valid && req_ready;
   assign is_rd     = accept && (req_beat.fmt == MRD);
   assign is_wr     = accept && (req_beat.fmt == MWR);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cpl_valid <= 1'b0;
         reqs      <= 16'd0;
         checksum  <= 32'd0;
         written   <= '0;
      end else begin
         if (accept)
            reqs <= reqs + 16'd1;
         if (is_wr)
            checksum <= checksum ^ req_beat.data;
         // disabling the port discards what the memory holds
         if (!cfg.enable)
            written <= '0;
         else if (is_wr)
            written[bank][word] <= 1'b1;
         if (is_rd)
            cpl_valid <= 1'b1;
         else if (cpl_ready)
            cpl_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (is_wr)
         mem[bank][word] <= req_beat.data;
      if (is_rd)
         cpl_beat <= '{fmt: CPLD, pf_vf: req_beat.pf_vf, tag: req_beat.tag, data: rd_data};
   end

   // only host requests travel this way; completions never come back in
   a_no_cpl_in: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid |-> req_beat.fmt != CPLD);

endmodule

// File: he_lb_engine.sv
`timescale 1ns/1ps
// Loopback exerciser stage. Writes are counted and folded into an XOR
// checksum; reads are answered one cycle later with addr XOR seed.

module he_lb_engine
   import pcie_hdr_pkg::*;
   import he_cfg_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  port_cfg_t   cfg,
   input  req_beat_t   req_beat,
   input  logic        req_valid,
   output logic        req_ready,
   output cpl_beat_t   cpl_beat,
   output logic        cpl_valid,
   input  logic        cpl_ready,
   output logic [15:0] reqs,
   output logic [31:0] checksum
);

   logic accept;
   logic is_rd;
   logic is_wr;

   // a request is taken only when the completion slot is free or draining
   assign req_ready = !cpl_valid || cpl_ready;
   assign accept    = req_valid && req_ready;
   assign is_rd     = accept && (req_beat.fmt == MRD);
   assign is_wr     = accept && (req_beat.fmt == MWR);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cpl_valid <= 1'b0;
         reqs      <= 16'd0;
         checksum  <= 32'd0;
      end else begin
         if (accept)
            reqs <= reqs + 16'd1;
         if (is_wr)
            checksum <= checksum ^ req_beat.data;
         // writes are posted and leave the completion slot alone
         if (is_rd)
            cpl_valid <= 1'b1;
         else if (cpl_ready)
            cpl_valid <= 1'b0;
      end
   end

   // the pattern depends only on the address and the port seed, so a host can predict it
   always_ff @(posedge clk) begin
      if (is_rd) begin
         cpl_beat <= '{fmt:   CPLD,
                       pf_vf: req_beat.pf_vf,
                       tag:   req_beat.tag,
                       data:  req_beat.addr ^ cfg.seed};
      end
   end

endmodule

// File: tlp_skid.sv
`timescale 1ns/1ps
// Two-entry register FIFO that cuts the ready path between pipeline
// stages. The item type is a parameter, so the same block carries request
// beats after decode and completion beats at egress.

module tlp_skid #(
   parameter type ITEM_T = logic
) (
   input  logic  clk,
   input  logic  rst_n,
   input  ITEM_T in_item,
   input  logic  in_valid,
   output logic  in_ready,
   output ITEM_T out_item,
   output logic  out_valid,
   input  logic  out_ready
);

   ITEM_T      mem [2];
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;
   logic       push;
   logic       pop;

   // ready depends only on occupancy, never on in_valid
   assign in_ready  = (count != 2'd2);
   assign out_valid = (count != 2'd0);
   assign out_item  = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (push)
            wr_ptr <= !wr_ptr;
         if (pop)
            rd_ptr <= !rd_ptr;
         count <= count + 2'(push) - 2'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_item;
   end

   // while full nothing is taken, so the producer must keep its item
   // offered and unchanged until a slot frees up
   a_full_hold: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid && !in_ready |=> in_valid && $stable(in_item));

endmodule

// File: tlp_rx_decode.sv
`timescale 1ns/1ps
// First stage of a port. Takes request beats from the host stream, drops
// those routed to another PF/VF or arriving while the port is disabled,
// and holds the accepted ones in an output register for the next stage.

module tlp_rx_decode
   import pcie_hdr_pkg::*;
   import he_cfg_pkg::*;
#(
   parameter pf_vf_info_t PORT_PF_VF = '0
) (
   input  logic      clk,
   input  logic      rst_n,
   input  port_cfg_t cfg,
   input  req_beat_t rx_beat,
   input  logic      rx_valid,
   output logic      rx_ready,
   output req_beat_t out_beat,
   output logic      out_valid,
   input  logic      out_ready,
   output logic      drop
);

   logic live;
   logic accept;
   logic match;

   // ready stays low until the first cycle after reset is released
   always_ff @(posedge clk) begin
      if (!rst_n)
         live <= 1'b0;
      else
         live <= 1'b1;
   end

   // the register can take a beat when empty or when it is being drained
   assign rx_ready = live && (!out_valid || out_ready);
   assign accept   = rx_valid && rx_ready;
   assign match    = cfg.enable && (rx_beat.pf_vf == PORT_PF_VF);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         drop      <= 1'b0;
      end else begin
         // a misrouted beat is still consumed, it only raises drop
         drop <= accept && !match;
         if (accept && match)
            out_valid <= 1'b1;
         else if (out_ready)
            out_valid <= 1'b0;
      end
   end

   // payload register, loaded only with routed beats
   always_ff @(posedge clk) begin
      if (accept && match)
         out_beat <= rx_beat;
   end

   // the downstream skid may stall, the offered beat must not change meanwhile
   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> $stable(out_beat));

endmodule

// File: he_cfg_pkg.sv
// Register map and per-port configuration and counter records for the APB
// block that controls the exerciser ports.

package he_cfg_pkg;

   // paddr width, bits 7:5 pick the port and bits 4:0 the register
   localparam int CSR_ADDR_W = 8;

   // register offsets inside one 32 byte port window
   localparam logic [4:0] CSR_ENABLE = 5'h00;
   localparam logic [4:0] CSR_SEED   = 5'h04;
   localparam logic [4:0] CSR_REQS   = 5'h08;
   localparam logic [4:0] CSR_DROPS  = 5'h0C;
   localparam logic [4:0] CSR_SUM    = 5'h10;

   // host writable settings of one port
   typedef struct packed {
      logic        enable;
      logic [31:0] seed;
   } port_cfg_t;

   // read-only statistics of one port
   typedef struct packed {
      logic [15:0] reqs;
      logic [15:0] drops;
      logic [31:0] checksum;
   } port_cnt_t;

endpackage

// File: pcie_hdr_pkg.sv
// Beat formats exchanged between the host request stream and the exerciser
// ports. Any module that builds, routes or inspects a beat imports this.

package pcie_hdr_pkg;

   // upper bound on the number of ports in one port group
   localparam int MAX_PORTS = 8;

   // routing identity of one port; every request is compared against it
   typedef struct packed {
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
   } pf_vf_info_t;

   // only the three beat kinds the exercisers need are encoded
   typedef enum logic [1:0] {
      MWR  = 2'b00,
      MRD  = 2'b01,
      CPLD = 2'b10
   } tlp_fmt_e;

   // single-beat request, addr is a dword aligned byte address
   // data is ignored for reads
   typedef struct packed {
      tlp_fmt_e    fmt;
      pf_vf_info_t pf_vf;
      logic [7:0]  tag;
      logic [31:0] addr;
      logic [31:0] data;
   } req_beat_t;

   // completion with data, returned once per read
   // tag and pf_vf are copied from the request it answers
   typedef struct packed {
      tlp_fmt_e    fmt;
      pf_vf_info_t pf_vf;
      logic [7:0]  tag;
      logic [31:0] data;
   } cpl_beat_t;

endpackage
